// File: logic/edn_defs.svh
/*
  EDN shared constants
  link widths, end point count and register port layout
*/
`ifndef EDN_DEFS_SVH
`define EDN_DEFS_SVH

// link widths
`define EDN_GENBITS_W 128
`define EDN_EP_BUS_W 32
`define EDN_CMD_W 32

// end points served by the arbiter
`define EDN_NUM_EP 4

// register port byte offsets
`define EDN_WB_ADR_W 4
`define EDN_REG_CMD_REQ 4'h0
`define EDN_REG_CMD_STS 4'h4
`define EDN_REG_INTR_STATE 4'h8
`define EDN_REG_INTR_ENABLE 4'hC

`endif

// File: logic/csrng_pkg.sv
/*
  CSRNG application link types
  command and genbits signals between the EDN core and the generator
*/
`include "edn_defs.svh"

package csrng_pkg;

  // core to generator
  typedef struct packed {
    logic                  req_valid;
    logic [`EDN_CMD_W-1:0] req_bus;
    logic                  genbits_ready;
  } csrng_req_t;

  // generator to core
  typedef struct packed {
    logic                      req_ready;
    logic                      rsp_ack;
    logic                      rsp_sts;
    logic                      genbits_valid;
    logic [`EDN_GENBITS_W-1:0] genbits_bus;
  } csrng_rsp_t;

endpackage

// File: logic/edn_pkg.sv
/*
  EDN end point and register port types
  per end point req/ack link and the Wishbone classic slave signals
*/
`include "edn_defs.svh"

package edn_pkg;

  // end point request held until ack
  typedef struct packed {
    logic edn_req;
  } edn_req_t;

  typedef struct packed {
    logic                     edn_ack;
    logic [`EDN_EP_BUS_W-1:0] edn_bus;
  } edn_rsp_t;

  // ----------------------------------------------------------
  // Wishbone classic
  // ----------------------------------------------------------
  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`EDN_WB_ADR_W-1:0] adr;
    logic [31:0]              dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage

// File: logic/edn_packer.sv
/*
  EDN packer FIFO
  holds one InW word and hands it out as InW/OutW slices, low slice first
*/
`timescale 1ns/1ns

module edn_packer #(
  parameter int InW  = 128,
  parameter int OutW = 32
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            wvalid_i,
  input  logic [InW-1:0]  wdata_i,
  output logic            wready_o,
  output logic            rvalid_o,
  output logic [OutW-1:0] rdata_o,
  input  logic            rready_i
);

  localparam int Ratio = InW / OutW;
  localparam int CntW  = $clog2(Ratio + 1);

  logic [InW-1:0]  data_q;
  logic [CntW-1:0] cnt_q;
  logic            push;
  logic            pop;

  // empty once the last slice has gone
  assign wready_o = (cnt_q == '0);
  assign rvalid_o = (cnt_q != '0);
  assign push     = wvalid_i && wready_o;
  assign pop      = rvalid_o && rready_i;

  // ----------------------------------------------------------
  // slice counter
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (push) begin
      cnt_q <= CntW'(Ratio);
    end else if (pop) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // word register shifts down one slice per pop
  always_ff @(posedge clk_i) begin
    if (push) begin
      data_q <= wdata_i;
    end else if (pop) begin
      data_q <= data_q >> OutW;
    end
  end

  assign rdata_o = data_q[OutW-1:0];

endmodule

// File: logic/edn_rr_arbiter.sv
/*
  EDN round-robin arbiter
  grants the buffered generator word to one requesting end point
*/
`timescale 1ns/1ns
`include "edn_defs.svh"

module edn_rr_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`EDN_NUM_EP-1:0] req_i,
  input  logic                   valid_i,
  output logic [`EDN_NUM_EP-1:0] gnt_o,
  output logic                   ready_o
);

  localparam int N    = `EDN_NUM_EP;
  localparam int IdxW = (N > 1) ? $clog2(N) : 1;

  logic [IdxW-1:0] ptr_q;
  logic [IdxW-1:0] win_idx;
  logic            found;

  // first request at or after the pointer
  always_comb begin
    int cand;
    found   = 1'b0;
    win_idx = '0;
    for (int k = 0; k < N; k++) begin
      cand = (int'(ptr_q) + k) % N;
      if (!found && req_i[cand]) begin
        found   = 1'b1;
        win_idx = IdxW'(cand);
      end
    end
  end

  assign ready_o = valid_i && found;
  assign gnt_o   = ready_o ? (N'(1) << win_idx) : '0;

  // pointer moves just past the winner
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (ready_o) begin
      ptr_q <= (int'(win_idx) == N - 1) ? '0 : win_idx + 1'b1;
    end
  end

endmodule

// File: logic/edn_ep_port.sv
/*
  EDN end point port
  128-to-32 packer drained by a req/ack state machine
*/
`timescale 1ns/1ns
`include "edn_defs.svh"

module edn_ep_port (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      push_i,
  input  logic [`EDN_GENBITS_W-1:0] wdata_i,
  output logic                      space_o,
  input  edn_pkg::edn_req_t         edn_i,
  output edn_pkg::edn_rsp_t         edn_o
);

  import edn_pkg::*;

  typedef enum logic {
    AckIdle,
    AckPulse
  } ack_state_e;

  ack_state_e               state_q;
  ack_state_e               state_d;
  logic                     wready;
  logic                     rvalid;
  logic                     rready;
  logic [`EDN_EP_BUS_W-1:0] rdata;

  edn_packer #(
    .InW  (`EDN_GENBITS_W),
    .OutW (`EDN_EP_BUS_W)
  ) u_packer (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (push_i),
    .wdata_i  (wdata_i),
    .wready_o (wready),
    .rvalid_o (rvalid),
    .rdata_o  (rdata),
    .rready_i (rready)
  );

  // ----------------------------------------------------------
  // ack FSM with a pulse then one idle cycle
  // ----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    rready  = 1'b0;
    case (state_q)
      AckIdle: begin
        if (edn_i.edn_req && rvalid) begin
          state_d = AckPulse;
        end
      end
      AckPulse: begin
        rready  = 1'b1;
        state_d = AckIdle;
      end
      default: state_d = AckIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= AckIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // arbiter only sees a requesting port with an empty packer
  assign space_o = edn_i.edn_req && wready;
  assign edn_o   = edn_rsp_t'{edn_ack: (state_q == AckPulse), edn_bus: rdata};

endmodule

// File: logic/edn_sw_cmd.sv
/*
  EDN software command block
  Wishbone classic register slave, one pending generator command,
  last response status and the command-done interrupt
*/
`timescale 1ns/1ns
`include "edn_defs.svh"

module edn_sw_cmd (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  edn_pkg::wb_req_t      wb_i,
  output edn_pkg::wb_rsp_t      wb_o,
  output logic                  cmd_valid_o,
  output logic [`EDN_CMD_W-1:0] cmd_bus_o,
  input  logic                  cmd_ready_i,
  input  logic                  cmd_ack_i,
  input  logic                  cmd_sts_i,
  output logic                  intr_o
);

  import edn_pkg::*;

  logic                  ack_q;
  logic                  wr_en;
  logic                  cmd_load;
  logic                  done_clr;
  logic [31:0]           rdata;
  logic                  cmd_valid_q;
  logic [`EDN_CMD_W-1:0] cmd_bus_q;
  logic                  sts_q;
  logic                  done_q;
  logic                  en_q;

  // ----------------------------------------------------------
  // bus handshake
  // ----------------------------------------------------------
  // single-cycle ack one cycle after the strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_i.cyc && wb_i.stb && !ack_q;
    end
  end

  // writes land in the ack cycle
  assign wr_en    = ack_q && wb_i.cyc && wb_i.stb && wb_i.we;
  assign cmd_load = wr_en && (wb_i.adr == `EDN_REG_CMD_REQ) && !cmd_valid_q;
  assign done_clr = wr_en && (wb_i.adr == `EDN_REG_INTR_STATE) && wb_i.dat[0];

  // ----------------------------------------------------------
  // command and interrupt state
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_valid_q <= 1'b0;
      sts_q       <= 1'b0;
      done_q      <= 1'b0;
      en_q        <= 1'b0;
    end else begin
      // held until the generator takes it
      if (cmd_load) begin
        cmd_valid_q <= 1'b1;
      end else if (cmd_ready_i) begin
        cmd_valid_q <= 1'b0;
      end
      if (cmd_ack_i) begin
        sts_q <= cmd_sts_i;
      end
      // a new ack wins over a clear in the same cycle
      if (cmd_ack_i) begin
        done_q <= 1'b1;
      end else if (done_clr) begin
        done_q <= 1'b0;
      end
      if (wr_en && (wb_i.adr == `EDN_REG_INTR_ENABLE)) begin
        en_q <= wb_i.dat[0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_load) begin
      cmd_bus_q <= wb_i.dat;
    end
  end

  // read mux where unmapped addresses and CMD_REQ read as zero
  always_comb begin
    rdata = '0;
    case (wb_i.adr)
      `EDN_REG_CMD_STS:     rdata[1:0] = {sts_q, cmd_ready_i};
      `EDN_REG_INTR_STATE:  rdata[0]   = done_q;
      `EDN_REG_INTR_ENABLE: rdata[0]   = en_q;
      default:              rdata      = '0;
    endcase
  end

  assign wb_o        = wb_rsp_t'{ack: ack_q, dat: rdata};
  assign cmd_valid_o = cmd_valid_q;
  assign cmd_bus_o   = cmd_bus_q;
  assign intr_o      = done_q && en_q;

endmodule

// File: logic/edn_core.sv
/*
  EDN core
  forwards software commands to the generator and spreads its 128-bit
  words over four end points, round-robin, as 32-bit words
*/
`timescale 1ns/1ns
`include "edn_defs.svh"

module edn_core (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  edn_pkg::wb_req_t                     wb_i,
  output edn_pkg::wb_rsp_t                     wb_o,
  output csrng_pkg::csrng_req_t                csrng_o,
  input  csrng_pkg::csrng_rsp_t                csrng_i,
  input  edn_pkg::edn_req_t [`EDN_NUM_EP-1:0]  edn_i,
  output edn_pkg::edn_rsp_t [`EDN_NUM_EP-1:0]  edn_o,
  output logic                                 intr_cmd_done_o
);

  import csrng_pkg::*;

  logic                      cmd_valid;
  logic [`EDN_CMD_W-1:0]     cmd_bus;
  logic                      cs_wready;
  logic                      cs_rvalid;
  logic                      cs_rready;
  logic [`EDN_GENBITS_W-1:0] cs_rdata;
  logic [`EDN_NUM_EP-1:0]    arb_req;
  logic [`EDN_NUM_EP-1:0]    arb_gnt;

  // ----------------------------------------------------------
  // register port and command link
  // ----------------------------------------------------------
  edn_sw_cmd u_sw_cmd (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_i        (wb_i),
    .wb_o        (wb_o),
    .cmd_valid_o (cmd_valid),
    .cmd_bus_o   (cmd_bus),
    .cmd_ready_i (csrng_i.req_ready),
    .cmd_ack_i   (csrng_i.rsp_ack),
    .cmd_sts_i   (csrng_i.rsp_sts),
    .intr_o      (intr_cmd_done_o)
  );

  assign csrng_o = csrng_req_t'{
    req_valid:     cmd_valid,
    req_bus:       cmd_bus,
    genbits_ready: cs_wready
  };

  // ----------------------------------------------------------
  // genbits buffer and distribution
  // ----------------------------------------------------------
  // one-word buffer whose ready drops while it holds a word
  edn_packer #(
    .InW  (`EDN_GENBITS_W),
    .OutW (`EDN_GENBITS_W)
  ) u_cs_buf (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (csrng_i.genbits_valid),
    .wdata_i  (csrng_i.genbits_bus),
    .wready_o (cs_wready),
    .rvalid_o (cs_rvalid),
    .rdata_o  (cs_rdata),
    .rready_i (cs_rready)
  );

  edn_rr_arbiter u_arb (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (arb_req),
    .valid_i (cs_rvalid),
    .gnt_o   (arb_gnt),
    .ready_o (cs_rready)
  );

  for (genvar i = 0; i < `EDN_NUM_EP; i++) begin : gen_ep
    edn_ep_port u_ep (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .push_i  (arb_gnt[i]),
      .wdata_i (cs_rdata),
      .space_o (arb_req[i]),
      .edn_i   (edn_i[i]),
      .edn_o   (edn_o[i])
    );
  end

endmodule

// File: verif/edn_clk_gen.sv
/*
  EDN testbench clock and reset
  20 ns clock, active-low reset held for 4 cycles
*/
`timescale 1ns/1ns

module edn_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // release on a falling edge away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: verif/edn_core_assert.sv
/*
  EDN core protocol assertions
  command hold, end point ack and Wishbone ack rules, bound to edn_core
*/
`timescale 1ns/1ns
`include "edn_defs.svh"

module edn_core_assert (
  input logic                                 clk_i,
  input logic                                 rst_ni,
  input edn_pkg::wb_req_t                     wb_i,
  input edn_pkg::wb_rsp_t                     wb_o,
  input csrng_pkg::csrng_req_t                csrng_o,
  input csrng_pkg::csrng_rsp_t                csrng_i,
  input edn_pkg::edn_req_t [`EDN_NUM_EP-1:0]  edn_i,
  input edn_pkg::edn_rsp_t [`EDN_NUM_EP-1:0]  edn_o
);

  int                     cmd_fails = 0;
  int                     ack_fails = 0;
  int                     wb_fails = 0;
  logic [`EDN_NUM_EP-1:0] ack_vec;
  logic [`EDN_NUM_EP-1:0] req_vec;

  always_comb begin
    for (int i = 0; i < `EDN_NUM_EP; i++) begin
      ack_vec[i] = edn_o[i].edn_ack;
      req_vec[i] = edn_i[i].edn_req;
    end
  end

  // pending command keeps its bus until the generator takes it
  cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csrng_o.req_valid && !csrng_i.req_ready |=>
      csrng_o.req_valid && $stable(csrng_o.req_bus))
    else begin
      $error("command dropped or changed before req_ready");
      cmd_fails++;
    end

  ack_with_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_vec & ~req_vec) == '0)
    else begin
      $error("edn_ack without edn_req");
      ack_fails++;
    end

  wb_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_o.ack |-> wb_i.cyc && wb_i.stb)
    else begin
      $error("Wishbone ack outside a bus cycle");
      wb_fails++;
    end

endmodule

bind edn_core edn_core_assert u_protocol_assert (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .wb_i    (wb_i),
  .wb_o    (wb_o),
  .csrng_o (csrng_o),
  .csrng_i (csrng_i),
  .edn_i   (edn_i),
  .edn_o   (edn_o)
);

// File: verif/edn_core_tb.sv
/*
  EDN core testbench
  generator and end point models, register tests, word delivery checks
*/
`timescale 1ns/1ns
`include "edn_defs.svh"

module edn_core_tb;

  import edn_pkg::*;
  import csrng_pkg::*;

  localparam int N         = `EDN_NUM_EP;
  localparam int SliceW    = `EDN_EP_BUS_W;
  localparam int Slices    = `EDN_GENBITS_W / `EDN_EP_BUS_W;
  localparam int MaxCycles = 20000;

  logic                      clk;
  logic                      rst_n;
  wb_req_t                   wb_req;
  wb_rsp_t                   wb_rsp;
  csrng_req_t                cs_req;
  csrng_rsp_t                cs_rsp;
  edn_req_t [N-1:0]          ep_req;
  edn_rsp_t [N-1:0]          ep_rsp;
  logic                      intr;

  integer                    seed = 65118;
  int                        errors;
  int                        tests;
  int                        failed_tests;
  int                        test_err0;
  int                        cycles;
  // model controls change on the rising edge only
  bit                        models_on;
  int                        cmd_mode;
  logic                      fixed_ready;
  int                        gen_mode;
  int                        gen_limit;
  int                        ep_mode;
  // command link model
  int                        xfer_cnt;
  int                        ack_cnt;
  int                        ack_wait;
  logic [`EDN_CMD_W-1:0]     xfer_bus;
  logic                      last_sts;
  // genbits tracking
  logic [`EDN_GENBITS_W-1:0] sent_q[$];
  bit                        used_q[$];
  int                        delivered;
  logic [`EDN_GENBITS_W-1:0] asm_word[N];
  int                        asm_cnt[N];
  int                        last_idx[N];
  int                        words_rx[N];
  bit                        got_ack[N];

  edn_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  edn_core i_edn_core (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .wb_i            (wb_req),
    .wb_o            (wb_rsp),
    .csrng_o         (cs_req),
    .csrng_i         (cs_rsp),
    .edn_i           (ep_req),
    .edn_o           (ep_rsp),
    .intr_cmd_done_o (intr)
  );

  function automatic logic rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  function automatic int rand_below(int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  function automatic logic [`EDN_GENBITS_W-1:0] rand_word();
    logic [`EDN_GENBITS_W-1:0] w;
    for (int k = 0; k < Slices; k++) begin
      w[SliceW*k +: SliceW] = $random(seed);
    end
    return w;
  endfunction

  task automatic check_word(string what, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(string what, logic got, logic exp);
    assert (got === exp) else begin
      $display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // ------------------------------------------------------------
  // generator and end point models
  // ------------------------------------------------------------
  task automatic drive_cmd_link();
    cs_rsp.rsp_ack = 1'b0;
    if (ack_wait > 0) begin
      ack_wait--;
      if (ack_wait == 0) begin
        cs_rsp.rsp_ack = 1'b1;
        cs_rsp.rsp_sts = rand_bit();
        last_sts       = cs_rsp.rsp_sts;
        ack_cnt++;
      end
    end
    cs_rsp.req_ready = (cmd_mode == 0) ? fixed_ready : rand_bit();
    // transfer happens on the coming rising edge
    if (cs_req.req_valid && cs_rsp.req_ready) begin
      xfer_cnt++;
      xfer_bus = cs_req.req_bus;
      ack_wait = 1 + rand_below(8);
    end
  endtask

  task automatic drive_genbits();
    cs_rsp.genbits_valid = 1'b0;
    if (gen_mode != 0 && sent_q.size() < gen_limit) begin
      cs_rsp.genbits_valid = (gen_mode == 2) ? 1'b1 : rand_bit();
    end
    cs_rsp.genbits_bus = rand_word();
    if (cs_rsp.genbits_valid && cs_req.genbits_ready) begin
      sent_q.push_back(cs_rsp.genbits_bus);
      used_q.push_back(1'b0);
    end
  endtask

  // four acks make one word that must be unused and newer than the last one
  task automatic collect_slice(int i, logic [SliceW-1:0] slice);
    int idx;
    asm_word[i][SliceW*asm_cnt[i] +: SliceW] = slice;
    asm_cnt[i]++;
    if (asm_cnt[i] == Slices) begin
      asm_cnt[i] = 0;
      idx = -1;
      foreach (sent_q[k]) begin
        if (idx < 0 && sent_q[k] == asm_word[i]) begin
          idx = k;
        end
      end
      assert (idx >= 0 && !used_q[idx] && idx > last_idx[i]) else begin
        $display("FAILED %0t: end point %0d got word %h, not a fresh word in order",
                 $time, i, asm_word[i]);
        errors++;
      end
      if (idx >= 0) begin
        used_q[idx] = 1'b1;
        last_idx[i] = idx;
      end
      words_rx[i]++;
      delivered++;
    end
  endtask

  task automatic drive_end_points();
    for (int i = 0; i < N; i++) begin
      // req stays up through the ack cycle
      if (ep_rsp[i].edn_ack) begin
        collect_slice(i, ep_rsp[i].edn_bus);
        got_ack[i] = 1'b1;
      end else if (ep_mode == 2) begin
        ep_req[i].edn_req = 1'b1;
      end else if (ep_mode == 1) begin
        if (ep_req[i].edn_req && got_ack[i]) begin
          if (rand_bit()) begin
            ep_req[i].edn_req = 1'b0;
            got_ack[i]        = 1'b0;
          end
        end else if (!ep_req[i].edn_req) begin
          ep_req[i].edn_req = (rand_below(4) == 0);
        end
      end
    end
  endtask

  always @(negedge clk) begin
    if (models_on) begin
      drive_cmd_link();
      drive_genbits();
      drive_end_points();
    end
  end

  always @(posedge clk) begin
    cycles++;
  end

  initial begin
    wait (cycles >= MaxCycles);
    $display("timeout: run did not finish within %0d cycles", MaxCycles);
    $display("TB FAILED");
    $finish;
  end

  // ------------------------------------------------------------
  // Wishbone master and test bookkeeping
  // ------------------------------------------------------------
  task automatic wb_access(input logic we, input logic [`EDN_WB_ADR_W-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    @(negedge clk);
    while (!wb_rsp.ack) @(negedge clk);
    rdat = wb_rsp.dat;
    // held through the ack cycle in which the write lands
    @(negedge clk);
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic reg_write(logic [`EDN_WB_ADR_W-1:0] adr, logic [31:0] dat);
    logic [31:0] rd;
    wb_access(1'b1, adr, dat, rd);
  endtask

  task automatic reg_read(input logic [`EDN_WB_ADR_W-1:0] adr, output logic [31:0] dat);
    wb_access(1'b0, adr, 32'h0, dat);
  endtask

  task automatic end_test(string name);
    tests++;
    if (errors != test_err0) begin
      failed_tests++;
      $display("test %0d %s: %0d errors", tests, name, errors - test_err0);
    end else begin
      $display("test %0d %s: ok", tests, name);
    end
    test_err0 = errors;
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] cmd;
    int          n0;
    int          lo;
    int          hi;
    int          rx0[N];
    wb_req = '0;
    cs_rsp = '0;
    ep_req = '0;
    fixed_ready = 1'b0;
    {cmd_mode, gen_mode, gen_limit, ep_mode} = '0;
    {errors, tests, failed_tests, test_err0, cycles} = '0;
    {xfer_cnt, ack_cnt, ack_wait, delivered} = '0;
    models_on = 1'b0;
    for (int i = 0; i < N; i++) begin
      asm_cnt[i]  = 0;
      last_idx[i] = -1;
      words_rx[i] = 0;
      got_ack[i]  = 1'b0;
    end
    wait (rst_n === 1'b1);
    @(negedge clk);
    for (int i = 0; i < N; i++) begin
      check_bit("edn_ack after reset", ep_rsp[i].edn_ack, 1'b0);
    end
    check_bit("req_valid after reset", cs_req.req_valid, 1'b0);
    check_bit("intr after reset", intr, 1'b0);
    check_bit("wb ack after reset", wb_rsp.ack, 1'b0);
    check_bit("genbits_ready after reset", cs_req.genbits_ready, 1'b1);
    end_test("reset values");

    @(posedge clk);
    models_on = 1'b1;
    reg_write(`EDN_REG_INTR_ENABLE, 32'h1);
    reg_read(`EDN_REG_INTR_ENABLE, rd);
    check_word("INTR_ENABLE", rd, 32'h1);
    // enable is set so an aliased decode shows up here
    for (int a = 0; a < 16; a++) begin
      if ((a % 4) != 0) begin
        reg_read(4'(a), rd);
        check_word("unmapped read", rd, 32'h0);
      end
    end
    reg_write(`EDN_REG_INTR_ENABLE, 32'h0);
    reg_write(4'hD, 32'hffff_ffff);
    reg_read(`EDN_REG_INTR_ENABLE, rd);
    check_word("INTR_ENABLE", rd, 32'h0);
    @(posedge clk);
    fixed_ready = 1'b1;
    reg_read(`EDN_REG_CMD_STS, rd);
    check_bit("CMD_STS ready", rd[0], 1'b1);
    @(posedge clk);
    fixed_ready = 1'b0;
    reg_read(`EDN_REG_CMD_STS, rd);
    check_bit("CMD_STS ready", rd[0], 1'b0);
    end_test("register access");

    @(posedge clk);
    cmd_mode = 1;
    for (int c = 0; c < 20; c++) begin
      cmd = $random(seed);
      n0  = xfer_cnt;
      reg_write(`EDN_REG_CMD_REQ, cmd);
      while (ack_cnt == n0) @(posedge clk);
      check_word("command bus", xfer_bus, cmd);
      check_word("transfer count", 32'(xfer_cnt), 32'(n0 + 1));
      reg_read(`EDN_REG_CMD_STS, rd);
      check_bit("CMD_STS status", rd[1], last_sts);
    end
    check_word("total transfers", 32'(xfer_cnt), 32'd20);
    check_bit("req_valid idle", cs_req.req_valid, 1'b0);
    end_test("command transfers");

    reg_write(`EDN_REG_INTR_STATE, 32'h1);
    reg_read(`EDN_REG_INTR_STATE, rd);
    check_word("INTR_STATE cleared", rd, 32'h0);
    n0 = ack_cnt;
    reg_write(`EDN_REG_CMD_REQ, 32'h0000_0a5c);
    while (ack_cnt == n0) @(posedge clk);
    reg_read(`EDN_REG_INTR_STATE, rd);
    check_word("INTR_STATE set", rd, 32'h1);
    check_bit("intr while disabled", intr, 1'b0);
    reg_write(`EDN_REG_INTR_ENABLE, 32'h1);
    check_bit("intr while enabled", intr, 1'b1);
    reg_write(`EDN_REG_INTR_STATE, 32'h1);
    reg_read(`EDN_REG_INTR_STATE, rd);
    check_word("INTR_STATE after clear", rd, 32'h0);
    check_bit("intr after clear", intr, 1'b0);
    reg_write(`EDN_REG_INTR_ENABLE, 32'h0);
    end_test("command done interrupt");

    // random requests and then all request to drain
    @(posedge clk);
    ep_mode   = 1;
    gen_limit = 200;
    gen_mode  = 1;
    while (sent_q.size() < 200) @(posedge clk);
    ep_mode = 2;
    while (delivered < 200) @(posedge clk);
    n0 = 0;
    foreach (used_q[k]) begin
      if (used_q[k]) n0++;
    end
    check_word("generator words delivered once", 32'(n0), 32'd200);
    end_test("random distribution");

    @(posedge clk);
    for (int i = 0; i < N; i++) begin
      rx0[i] = words_rx[i];
    end
    gen_limit = 260;
    gen_mode  = 2;
    while (delivered < 260) @(posedge clk);
    lo = words_rx[0] - rx0[0];
    hi = lo;
    for (int i = 1; i < N; i++) begin
      if (words_rx[i] - rx0[i] < lo) lo = words_rx[i] - rx0[i];
      if (words_rx[i] - rx0[i] > hi) hi = words_rx[i] - rx0[i];
    end
    assert (hi - lo <= 1) else begin
      $display("FAILED %0t: round-robin spread %0d to %0d words", $time, lo, hi);
      errors++;
    end
    end_test("round-robin fairness");

    errors += i_edn_core.u_protocol_assert.cmd_fails;
    errors += i_edn_core.u_protocol_assert.ack_fails;
    errors += i_edn_core.u_protocol_assert.wb_fails;
    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+logic
logic/csrng_pkg.sv
logic/edn_pkg.sv
logic/edn_packer.sv
logic/edn_rr_arbiter.sv
logic/edn_ep_port.sv
logic/edn_sw_cmd.sv
logic/edn_core.sv
verif/edn_clk_gen.sv
verif/edn_core_assert.sv
verif/edn_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the EDN core testbench with Verilator
set -e

verilator --binary --timing --assert -f list.f --top-module edn_core_tb -o edn_core_sim
out=$(./obj_dir/edn_core_sim)
echo "$out"
if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
